// File: hw/fas_pkg.sv
// fas_pkg: shared widths and constant tables for the FIR, FFT and peak search
package fas_pkg;

    // sample stream and filter
    localparam int SAMPLE_W = 16;
    localparam int FIR_TAPS = 32;
    localparam int COEF_W   = 16;
    localparam int FRAC_W   = 16;

    // windowed-sinc low-pass, cutoff near fs/4
    // entry k weights the tap pair (k, FIR_TAPS-1-k), outermost pair first
    localparam logic signed [COEF_W-1:0] FIR_COEF [FIR_TAPS/2] = '{
        -16'sd76,
        -16'sd91,
        16'sd128,
        16'sd192,
        -16'sd286,
        -16'sd417,
        16'sd590,
        16'sd816,
        -16'sd1108,
        -16'sd1487,
        16'sd1991,
        16'sd2693,
        -16'sd3747,
        -16'sd5559,
        16'sd9626,
        16'sd29436
    };

    // transform
    localparam int FFT_N      = 16;
    localparam int BIN_W      = 4;
    localparam int BIN_DATA_W = 24;
    localparam int TW_W       = 18;

    // W16^k for k = 0..7, Q16
    localparam logic signed [TW_W-1:0] TW_RE [FFT_N/2] = '{
        18'sd65536,
        18'sd60547,
        18'sd46340,
        18'sd25079,
        18'sd0,
        -18'sd25079,
        -18'sd46340,
        -18'sd60547
    };

    localparam logic signed [TW_W-1:0] TW_IM [FFT_N/2] = '{
        18'sd0,
        -18'sd25079,
        -18'sd46340,
        -18'sd60547,
        -18'sd65536,
        -18'sd60547,
        -18'sd46340,
        -18'sd25079
    };

    // peak search over the non-mirrored half of a real spectrum
    localparam int MAG_W     = 48;
    localparam int PEAK_BINS = FFT_N/2 + 1;

endpackage

// File: hw/fir_filter.sv
// fir_filter: 32-tap symmetric low-pass FIR with pre-added tap pairs and registered output
module fir_filter #(
    parameter int SAMPLE_W = fas_pkg::SAMPLE_W
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       data_valid_i,
    input  logic signed [SAMPLE_W-1:0] data_i,
    output logic                       fir_valid_o,
    output logic signed [SAMPLE_W-1:0] fir_d_o
);

    localparam int TAPS   = fas_pkg::FIR_TAPS;
    localparam int PAIRS  = TAPS / 2;
    localparam int PAIR_W = SAMPLE_W + 1;
    localparam int PROD_W = PAIR_W + fas_pkg::COEF_W;
    localparam int ACC_W  = PROD_W + $clog2(PAIRS);
    localparam int CNT_W  = $clog2(TAPS + 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(TAPS);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(TAPS - 1);

    logic signed [SAMPLE_W-1:0] taps [TAPS-1];
    logic signed [SAMPLE_W-1:0] window [TAPS];
    logic signed [PAIR_W-1:0]   pair [PAIRS];
    logic signed [PROD_W-1:0]   prod [PAIRS];
    logic signed [ACC_W-1:0]    acc;
    logic [CNT_W-1:0]           fill_cnt;

    // incoming sample is x[n], so the result is ready at the accepting edge
    assign window[0] = data_i;
    for (genvar i = 1; i < TAPS; i++) begin : g_window
        assign window[i] = taps[i-1];
    end

    // pre-add mirrored taps, one multiply per pair
    for (genvar k = 0; k < PAIRS; k++) begin : g_pair
        assign pair[k] = window[k] + window[TAPS-1-k];
        assign prod[k] = pair[k] * fas_pkg::FIR_COEF[k];
    end

    always_comb begin
        acc = '0;
        for (int k = 0; k < PAIRS; k++) begin
            acc = acc + prod[k];
        end
    end

    always_ff @(posedge clk) begin
        if (data_valid_i) begin
            taps[0] <= data_i;
            for (int i = 1; i < TAPS - 1; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    // fill count saturates once the window is full
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_cnt    <= '0;
            fir_valid_o <= 1'b0;
        end else begin
            fir_valid_o <= data_valid_i && (fill_cnt >= LAST);
            if (data_valid_i && fill_cnt != FULL) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

    // drop Q16 fraction, keep low sample bits
    always_ff @(posedge clk) begin
        if (data_valid_i) begin
            fir_d_o <= acc[fas_pkg::FRAC_W +: SAMPLE_W];
        end
    end

endmodule

// File: hw/frame_buffer.sv
// frame_buffer: collects 16 consecutive filtered samples into one FFT frame
module frame_buffer #(
    parameter int SAMPLE_W = fas_pkg::SAMPLE_W
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       fir_valid_i,
    input  logic signed [SAMPLE_W-1:0] fir_d_i,
    output logic                       frame_valid_o,
    output logic signed [SAMPLE_W-1:0] frame_o [fas_pkg::FFT_N]
);

    localparam int BW = fas_pkg::BIN_W;
    localparam logic [BW-1:0] LAST_SLOT = BW'(fas_pkg::FFT_N - 1);

    logic [BW-1:0] slot;

    // slot counter wraps, so frames never overlap
    always_ff @(posedge clk) begin
        if (rst) begin
            slot          <= '0;
            frame_valid_o <= 1'b0;
        end else begin
            frame_valid_o <= fir_valid_i && (slot == LAST_SLOT);
            if (fir_valid_i) begin
                slot <= slot + 1'b1;
            end
        end
    end

    // slots hold until the next frame overwrites them
    always_ff @(posedge clk) begin
        if (fir_valid_i) begin
            frame_o[slot] <= fir_d_i;
        end
    end

endmodule

// File: hw/radix4_butterfly.sv
// radix4_butterfly: 4-point DFT followed by a per-output twiddle rotation
module radix4_butterfly #(
    parameter int TW_STEP = 0
) (
    input  logic signed [fas_pkg::BIN_DATA_W-1:0] in_re_i  [4],
    input  logic signed [fas_pkg::BIN_DATA_W-1:0] in_im_i  [4],
    output logic signed [fas_pkg::BIN_DATA_W-1:0] out_re_o [4],
    output logic signed [fas_pkg::BIN_DATA_W-1:0] out_im_o [4]
);

    localparam int W      = fas_pkg::BIN_DATA_W;
    localparam int N      = fas_pkg::FFT_N;
    localparam int HALF   = N / 2;
    localparam int PROD_W = W + fas_pkg::TW_W + 1;

    logic signed [W-1:0] s0_re, s0_im, s1_re, s1_im;
    logic signed [W-1:0] t0_re, t0_im, t1_re, t1_im;
    logic signed [W-1:0] y_re [4];
    logic signed [W-1:0] y_im [4];

    assign s0_re = in_re_i[0] + in_re_i[2];
    assign s0_im = in_im_i[0] + in_im_i[2];
    assign s1_re = in_re_i[0] - in_re_i[2];
    assign s1_im = in_im_i[0] - in_im_i[2];
    assign t0_re = in_re_i[1] + in_re_i[3];
    assign t0_im = in_im_i[1] + in_im_i[3];
    assign t1_re = in_re_i[1] - in_re_i[3];
    assign t1_im = in_im_i[1] - in_im_i[3];

    // -j times t1 is (t1_im, -t1_re)
    assign y_re[0] = s0_re + t0_re;
    assign y_im[0] = s0_im + t0_im;
    assign y_re[1] = s1_re + t1_im;
    assign y_im[1] = s1_im - t1_re;
    assign y_re[2] = s0_re - t0_re;
    assign y_im[2] = s0_im - t0_im;
    assign y_re[3] = s1_re - t1_im;
    assign y_im[3] = s1_im + t1_re;

    for (genvar m = 0; m < 4; m++) begin : g_twiddle
        localparam int K = (m * TW_STEP) % N;

        if (K == 0) begin : g_bypass
            assign out_re_o[m] = y_re[m];
            assign out_im_o[m] = y_im[m];
        end else begin : g_rotate
            // upper half of the circle is the negated lower half
            localparam logic signed [fas_pkg::TW_W-1:0] WR =
                (K < HALF) ? fas_pkg::TW_RE[K % HALF] : -fas_pkg::TW_RE[K % HALF];
            localparam logic signed [fas_pkg::TW_W-1:0] WI =
                (K < HALF) ? fas_pkg::TW_IM[K % HALF] : -fas_pkg::TW_IM[K % HALF];

            logic signed [PROD_W-1:0] prod_re;
            logic signed [PROD_W-1:0] prod_im;

            assign prod_re = y_re[m] * WR - y_im[m] * WI;
            assign prod_im = y_re[m] * WI + y_im[m] * WR;

            // bit slice truncates toward minus infinity
            assign out_re_o[m] = prod_re[fas_pkg::FRAC_W +: W];
            assign out_im_o[m] = prod_im[fas_pkg::FRAC_W +: W];
        end
    end

endmodule

// File: hw/fft16.sv
// fft16: two-stage radix-4 16-point FFT with registered bins 0 to 8
module fft16 #(
    parameter int SAMPLE_W = fas_pkg::SAMPLE_W
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  frame_valid_i,
    input  logic signed [SAMPLE_W-1:0]            frame_i  [fas_pkg::FFT_N],
    output logic                                  bins_valid_o,
    output logic signed [fas_pkg::BIN_DATA_W-1:0] bin_re_o [fas_pkg::PEAK_BINS],
    output logic signed [fas_pkg::BIN_DATA_W-1:0] bin_im_o [fas_pkg::PEAK_BINS]
);

    localparam int W     = fas_pkg::BIN_DATA_W;
    localparam int RADIX = 4;

    // first index selects the butterfly, second its port
    logic signed [W-1:0] s1_in_re  [RADIX][RADIX];
    logic signed [W-1:0] s1_in_im  [RADIX][RADIX];
    logic signed [W-1:0] s1_out_re [RADIX][RADIX];
    logic signed [W-1:0] s1_out_im [RADIX][RADIX];
    logic signed [W-1:0] s2_in_re  [RADIX][RADIX];
    logic signed [W-1:0] s2_in_im  [RADIX][RADIX];
    logic signed [W-1:0] s2_out_re [RADIX][RADIX];
    logic signed [W-1:0] s2_out_im [RADIX][RADIX];

    // stage 1: butterfly g takes x[4*n1+g], rotated by W16^(g*k1)
    for (genvar g = 0; g < RADIX; g++) begin : g_stage1
        for (genvar n1 = 0; n1 < RADIX; n1++) begin : g_in
            assign s1_in_re[g][n1] = W'(frame_i[RADIX*n1 + g]);
            assign s1_in_im[g][n1] = '0;
        end

        radix4_butterfly #(
            .TW_STEP(g)
        ) u_bfly (
            .in_re_i (s1_in_re[g]),
            .in_im_i (s1_in_im[g]),
            .out_re_o(s1_out_re[g]),
            .out_im_o(s1_out_im[g])
        );
    end

    // stage 2: butterfly k1 combines output k1 of every first-stage group
    for (genvar k1 = 0; k1 < RADIX; k1++) begin : g_stage2
        for (genvar n2 = 0; n2 < RADIX; n2++) begin : g_in
            assign s2_in_re[k1][n2] = s1_out_re[n2][k1];
            assign s2_in_im[k1][n2] = s1_out_im[n2][k1];
        end

        radix4_butterfly #(
            .TW_STEP(0)
        ) u_bfly (
            .in_re_i (s2_in_re[k1]),
            .in_im_i (s2_in_im[k1]),
            .out_re_o(s2_out_re[k1]),
            .out_im_o(s2_out_im[k1])
        );
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bins_valid_o <= 1'b0;
        end else begin
            bins_valid_o <= frame_valid_i;
        end
    end

    // bin k1 + 4*k2 sits on output k2 of butterfly k1
    always_ff @(posedge clk) begin
        if (frame_valid_i) begin
            for (int b = 0; b < fas_pkg::PEAK_BINS; b++) begin
                bin_re_o[b] <= s2_out_re[b % RADIX][b / RADIX];
                bin_im_o[b] <= s2_out_im[b % RADIX][b / RADIX];
            end
        end
    end

endmodule

// File: hw/peak_picker.sv
// peak_picker: squared magnitude per bin and lowest-index maximum search
module peak_picker (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  bins_valid_i,
    input  logic signed [fas_pkg::BIN_DATA_W-1:0] bin_re_i [fas_pkg::PEAK_BINS],
    input  logic signed [fas_pkg::BIN_DATA_W-1:0] bin_im_i [fas_pkg::PEAK_BINS],
    output logic                                  done_o,
    output logic [fas_pkg::BIN_W-1:0]             freq_o
);

    localparam int NB     = fas_pkg::PEAK_BINS;
    localparam int BW     = fas_pkg::BIN_W;
    localparam int MW     = fas_pkg::MAG_W;
    localparam int LEVELS = $clog2(NB);

    logic [MW-1:0] mag [NB];
    logic [BW-1:0] best_idx;

    for (genvar b = 0; b < NB; b++) begin : g_mag
        assign mag[b] = bin_re_i[b] * bin_re_i[b] + bin_im_i[b] * bin_im_i[b];
    end

    // pairwise tree, left entry is always the lower bin and wins a tie
    always_comb begin : tree
        logic [MW-1:0] lvl_mag [2*NB];
        logic [BW-1:0] lvl_idx [2*NB];
        int            n;

        for (int b = 0; b < NB; b++) begin
            lvl_mag[b] = mag[b];
            lvl_idx[b] = BW'(b);
        end
        for (int b = NB; b < 2*NB; b++) begin
            lvl_mag[b] = '0;
            lvl_idx[b] = '0;
        end
        n = NB;
        for (int l = 0; l < LEVELS; l++) begin
            for (int i = 0; i < NB; i++) begin
                if (2*i + 1 < n) begin
                    if (lvl_mag[2*i+1] > lvl_mag[2*i]) begin
                        lvl_mag[i] = lvl_mag[2*i+1];
                        lvl_idx[i] = lvl_idx[2*i+1];
                    end else begin
                        lvl_mag[i] = lvl_mag[2*i];
                        lvl_idx[i] = lvl_idx[2*i];
                    end
                end else if (2*i < n) begin
                    // odd one out moves up unchanged
                    lvl_mag[i] = lvl_mag[2*i];
                    lvl_idx[i] = lvl_idx[2*i];
                end
            end
            n = (n + 1) / 2;
        end
        best_idx = lvl_idx[0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done_o <= 1'b0;
            freq_o <= '0;
        end else begin
            done_o <= bins_valid_i;
            if (bins_valid_i) begin
                freq_o <= best_idx;
            end
        end
    end

endmodule

// File: hw/fas_top.sv
// fas_top: FIR filter, frame buffer, 16-point FFT and peak search in one pipeline
module fas_top #(
    parameter int SAMPLE_W = fas_pkg::SAMPLE_W
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       data_valid_i,
    input  logic signed [SAMPLE_W-1:0] data_i,
    output logic                       fir_valid_o,
    output logic signed [SAMPLE_W-1:0] fir_d_o,
    output logic                       done_o,
    output logic [fas_pkg::BIN_W-1:0]  freq_o
);

    logic                                  frame_valid;
    logic signed [SAMPLE_W-1:0]            frame [fas_pkg::FFT_N];
    logic                                  bins_valid;
    logic signed [fas_pkg::BIN_DATA_W-1:0] bin_re [fas_pkg::PEAK_BINS];
    logic signed [fas_pkg::BIN_DATA_W-1:0] bin_im [fas_pkg::PEAK_BINS];

    fir_filter #(
        .SAMPLE_W(SAMPLE_W)
    ) u_fir_filter (
        .clk         (clk),
        .rst         (rst),
        .data_valid_i(data_valid_i),
        .data_i      (data_i),
        .fir_valid_o (fir_valid_o),
        .fir_d_o     (fir_d_o)
    );

    // filtered stream feeds both the outputs and the framer
    frame_buffer #(
        .SAMPLE_W(SAMPLE_W)
    ) u_frame_buffer (
        .clk          (clk),
        .rst          (rst),
        .fir_valid_i  (fir_valid_o),
        .fir_d_i      (fir_d_o),
        .frame_valid_o(frame_valid),
        .frame_o      (frame)
    );

    fft16 #(
        .SAMPLE_W(SAMPLE_W)
    ) u_fft16 (
        .clk          (clk),
        .rst          (rst),
        .frame_valid_i(frame_valid),
        .frame_i      (frame),
        .bins_valid_o (bins_valid),
        .bin_re_o     (bin_re),
        .bin_im_o     (bin_im)
    );

    peak_picker u_peak_picker (
        .clk         (clk),
        .rst         (rst),
        .bins_valid_i(bins_valid),
        .bin_re_i    (bin_re),
        .bin_im_i    (bin_im),
        .done_o      (done_o),
        .freq_o      (freq_o)
    );

endmodule

// File: tb/tb_fas.sv
// tb_fas: directed testbench for the FIR, FFT and peak search pipeline
module tb_fas;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int  SW            = fas_pkg::SAMPLE_W;
    localparam int  TAPS          = fas_pkg::FIR_TAPS;
    localparam int  N             = fas_pkg::FFT_N;
    localparam int  DRAIN_TIMEOUT = 200;
    localparam real PI            = 3.14159265358979;
    localparam real TONE_AMP      = 30000.0;

    logic                      clk;
    logic                      rst;
    logic                      data_valid_i;
    logic signed [SW-1:0]      data_i;
    logic                      fir_valid_o;
    logic signed [SW-1:0]      fir_d_o;
    logic                      done_o;
    logic [fas_pkg::BIN_W-1:0] freq_o;

    // reference model state, newest sample at the back of hist
    longint               hist [$];
    logic signed [SW-1:0] exp_fir [$];
    real                  frame_acc [$];
    int                   exp_freq [$];
    int                   err_cnt;
    int                   chk_cnt;
    int                   cycle;
    int                   fir_cnt;
    int                   done_cnt;
    int                   frame_end_cyc;

    fas_top #(
        .SAMPLE_W(SW)
    ) u_fas_top (
        .clk         (clk),
        .rst         (rst),
        .data_valid_i(data_valid_i),
        .data_i      (data_i),
        .fir_valid_o (fir_valid_o),
        .fir_d_o     (fir_d_o),
        .done_o      (done_o),
        .freq_o      (freq_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic signed [SW-1:0] fir_model();
        longint acc;
        int     last;
        acc  = 0;
        last = hist.size() - 1;
        for (int k = 0; k < TAPS / 2; k++) begin
            acc += (hist[last-k] + hist[last-TAPS+1+k]) * longint'(fas_pkg::FIR_COEF[k]);
        end
        return SW'(acc >>> 16);
    endfunction

    // real DFT over bins 0 to 8; -1 marks a frame whose peak is too close to call
    task automatic push_frame_peak();
        real mag [fas_pkg::PEAK_BINS];
        real re;
        real im;
        real second;
        int  best;
        for (int k = 0; k < fas_pkg::PEAK_BINS; k++) begin
            re = 0.0;
            im = 0.0;
            for (int i = 0; i < N; i++) begin
                re += frame_acc[i] * $cos(2.0 * PI * k * i / N);
                im -= frame_acc[i] * $sin(2.0 * PI * k * i / N);
            end
            mag[k] = re * re + im * im;
        end
        best = 0;
        for (int k = 1; k < fas_pkg::PEAK_BINS; k++) begin
            if (mag[k] > mag[best]) begin
                best = k;
            end
        end
        second = 0.0;
        for (int k = 0; k < fas_pkg::PEAK_BINS; k++) begin
            if (k != best && mag[k] > second) begin
                second = mag[k];
            end
        end
        // an all-zero spectrum falls to the tie rule
        if (mag[best] == 0.0 || mag[best] >= 1.2 * second) begin
            exp_freq.push_back(best);
        end else begin
            exp_freq.push_back(-1);
        end
        frame_acc.delete();
    endtask

    task automatic accept_sample(input logic signed [SW-1:0] d);
        logic signed [SW-1:0] y;
        hist.push_back(longint'(d));
        if (hist.size() > TAPS) begin
            void'(hist.pop_front());
        end
        if (hist.size() == TAPS) begin
            y = fir_model();
            exp_fir.push_back(y);
            frame_acc.push_back(real'(y));
            if (frame_acc.size() == N) begin
                push_frame_peak();
            end
        end
    endtask

    // outputs sampled at the falling edge, half a cycle after they change
    task automatic observe();
        logic signed [SW-1:0] exp_d;
        int                   exp_f;
        if (fir_valid_o) begin
            fir_cnt++;
            assert (exp_fir.size() > 0) else begin
                $display("fir_valid_o pulsed with no filter output due at time %0t", $time);
                err_cnt++;
            end
            if (exp_fir.size() > 0) begin
                exp_d = exp_fir.pop_front();
                chk_cnt++;
                assert (fir_d_o == exp_d) else begin
                    $display("Fail at %0t: fir_d_o is %0d, expected %0d", $time, fir_d_o, exp_d);
                    err_cnt++;
                end
            end
            if (fir_cnt % N == 0) begin
                frame_end_cyc = cycle;
            end
        end
        if (done_o) begin
            done_cnt++;
            assert (exp_freq.size() > 0) else begin
                $display("done_o pulsed with no completed frame at time %0t", $time);
                err_cnt++;
            end
            if (exp_freq.size() > 0) begin
                exp_f = exp_freq.pop_front();
                chk_cnt++;
                assert (cycle - frame_end_cyc <= 4) else begin
                    $display("Fail at %0t: done_o %0d cycles after frame end", $time,
                             cycle - frame_end_cyc);
                    err_cnt++;
                end
                if (exp_f >= 0) begin
                    chk_cnt++;
                    assert (freq_o == exp_f) else begin
                        $display("Fail at %0t: freq_o is %0d, expected %0d", $time, freq_o, exp_f);
                        err_cnt++;
                    end
                end
            end
        end
    endtask

    task automatic step(input logic v, input logic signed [SW-1:0] d);
        @(negedge clk);
        cycle++;
        observe();
        data_valid_i = v;
        data_i       = d;
        if (v) begin
            accept_sample(d);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst          = 1'b1;
        data_valid_i = 1'b0;
        data_i       = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        hist.delete();
        exp_fir.delete();
        frame_acc.delete();
        exp_freq.delete();
        fir_cnt  = 0;
        done_cnt = 0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((exp_fir.size() > 0 || exp_freq.size() > 0) && waited < DRAIN_TIMEOUT) begin
            step(1'b0, '0);
            waited++;
        end
        assert (exp_fir.size() == 0 && exp_freq.size() == 0) else begin
            $display("timed out waiting for outstanding outputs at time %0t", $time);
            err_cnt++;
        end
        // idle cycles catch stray pulses
        repeat (6) step(1'b0, '0);
    endtask

    task automatic expect_count(input string what, input int got, input int want);
        chk_cnt++;
        assert (got == want) else begin
            $display("Fail at %0t: %0d %s pulses, expected %0d", $time, got, what, want);
            err_cnt++;
        end
    endtask

    task automatic test_idle();
        apply_reset();
        repeat (20) step(1'b0, '0);
        expect_count("fir_valid_o", fir_cnt, 0);
        expect_count("done_o", done_cnt, 0);
    endtask

    task automatic test_impulse();
        apply_reset();
        repeat (TAPS - 1) step(1'b1, '0);
        step(1'b1, 16'sd32767);
        repeat (TAPS - 1) step(1'b1, '0);
        drain();
        expect_count("fir_valid_o", fir_cnt, TAPS);
    endtask

    task automatic test_random();
        int   accepted;
        logic v;
        accepted = 0;
        apply_reset();
        while (accepted < 200) begin
            v = ($urandom % 4) != 0;
            step(v, SW'($urandom));
            if (v) begin
                accepted++;
            end
        end
        drain();
        expect_count("fir_valid_o", fir_cnt, accepted - (TAPS - 1));
    endtask

    task automatic test_tones();
        for (int b = 1; b <= 3; b++) begin
            apply_reset();
            for (int i = 0; i < TAPS - 1 + 4 * N; i++) begin
                step(1'b1, SW'($rtoi(TONE_AMP * $sin(2.0 * PI * b * i / N))));
            end
            drain();
            expect_count("done_o", done_cnt, 4);
        end
    endtask

    task automatic test_zero();
        apply_reset();
        repeat (TAPS - 1 + 2 * N) step(1'b1, '0);
        drain();
        expect_count("done_o", done_cnt, 2);
        chk_cnt++;
        assert (freq_o == 0) else begin
            $display("Fail at %0t: freq_o is %0d for zero input, expected 0", $time, freq_o);
            err_cnt++;
        end
    endtask

    task automatic test_back_to_back();
        apply_reset();
        repeat (TAPS - 1 + 5 * N) step(1'b1, SW'($urandom));
        drain();
        expect_count("done_o", done_cnt, 5);
    endtask

    initial begin
        err_cnt       = 0;
        chk_cnt       = 0;
        cycle         = 0;
        frame_end_cyc = 0;
        rst           = 1'b1;
        data_valid_i  = 1'b0;
        data_i        = '0;
        void'($urandom(43612));
        test_idle();
        test_impulse();
        test_random();
        test_tones();
        test_zero();
        test_back_to_back();
        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
hw/fas_pkg.sv
hw/fir_filter.sv
hw/frame_buffer.sv
hw/radix4_butterfly.sv
hw/fft16.sv
hw/peak_picker.sv
hw/fas_top.sv
tb/tb_fas.sv

// File: Makefile
VERILATOR ?= verilator
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_fas
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
